// ==== include/ising_config.svh ====
// array size, coupling and bias widths, energy and counter widths, weight FIFO depth
`ifndef ISING_CONFIG_SVH
`define ISING_CONFIG_SVH

// array size
`define ISING_NUM_SPIN 16
`define ISING_PARALLELISM 4
`define ISING_NUM_BLK (`ISING_NUM_SPIN / `ISING_PARALLELISM)

// block address into the J memory
`define ISING_ADDR_BIT $clog2(`ISING_NUM_SPIN / `ISING_PARALLELISM)

// signed width shared by J weights and h biases
`define ISING_BITJ 4

// unsigned h scaling factor
`define ISING_SCALING_BIT 4

`define ISING_ENERGY_BIT 32

// measurement counter
`define ISING_CNT_BIT 32

// prefetch depth for weight blocks
`define ISING_WFIFO_DEPTH 2

`endif

// ==== list.f ====
+incdir+include
rtl/ising_pkg.sv
rtl/stream_fifo.sv
rtl/weight_fetch.sv
rtl/block_energy.sv
rtl/cycle_counter.sv
rtl/energy_monitor.sv
rtl/ising_energy_top.sv
verif/ising_energy_properties.sv
verif/tb_ising_energy.sv

// ==== rtl/block_energy.sv ====
// block_energy: registered partial energy of one weight block against the spin vector
`timescale 1ns/1ps
`include "ising_config.svh"

module block_energy (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    blk_valid_i,
    input  ising_pkg::weight_blk_t  blk_i,
    input  ising_pkg::blk_addr_t    blk_idx_i,
    input  logic                    last_i,
    input  ising_pkg::spin_vec_t    spin_i,
    input  ising_pkg::hbias_vec_t   hbias_i,
    input  ising_pkg::hscale_t      hscale_i,
    output ising_pkg::partial_t     part_o
);

    import ising_pkg::*;

    localparam int NUM_SPIN = `ISING_NUM_SPIN;
    localparam int PAR      = `ISING_PARALLELISM;
    localparam int BITJ     = `ISING_BITJ;

    energy_t block_sum;
    energy_t energy_q;
    logic    valid_q;
    logic    last_q;

    always_comb begin
        energy_t field;
        energy_t wj;
        int      row;
        block_sum = '0;
        for (int r = 0; r < PAR; r++) begin
            row   = int'(blk_idx_i) * PAR + r;
            // h term of this row, scale is unsigned
            field = energy_t'(signed'(hbias_i[row*BITJ +: BITJ])) * energy_t'(hscale_i);
            for (int j = 0; j < NUM_SPIN; j++) begin
                wj    = energy_t'(signed'(blk_i[(r*NUM_SPIN + j)*BITJ +: BITJ]));
                field = spin_i[j] ? field + wj : field - wj;
            end
            // weight the local field by the row's own spin
            block_sum = spin_i[row] ? block_sum + field : block_sum - field;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= blk_valid_i;
            last_q  <= blk_valid_i & last_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (blk_valid_i) begin
            energy_q <= block_sum;
        end
    end

    assign part_o = '{energy: energy_q, last: last_q, valid: valid_q};

endmodule

// ==== rtl/cycle_counter.sv ====
// cycle_counter: saturating busy-cycle counter cleared at the start of each computation
`timescale 1ns/1ps

module cycle_counter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  logic                   busy_i,
    output ising_pkg::cycle_cnt_t  count_o
);

    import ising_pkg::*;

    cycle_cnt_t count_q;
    logic       at_max;

    assign at_max = (count_q == '1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (start_i) begin
            count_q <= '0;
        end else if (busy_i && !at_max) begin
            count_q <= count_q + 1'b1;
        end
    end

    // holds the last value after the computation ends
    assign count_o = count_q;

endmodule

// ==== rtl/energy_monitor.sv ====
// energy_monitor: spin capture, block sequencing, energy accumulation, h scale latch, result FIFO
`timescale 1ns/1ps
`include "ising_config.svh"

module energy_monitor (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    config_valid_i,
    input  ising_pkg::hscale_t      hscaling_i,
    input  ising_pkg::hbias_vec_t   hbias_i,
    input  logic                    spin_valid_i,
    output logic                    spin_ready_o,
    input  ising_pkg::spin_vec_t    spin_i,
    input  logic                    blk_valid_i,
    output logic                    blk_ready_o,
    input  ising_pkg::weight_blk_t  blk_i,
    output logic                    energy_valid_o,
    input  logic                    energy_ready_i,
    output ising_pkg::energy_t      energy_o,
    output logic                    busy_o,
    output logic                    start_o
);

    import ising_pkg::*;

    localparam int NUM_BLK = `ISING_NUM_BLK;

    logic      config_valid_q;
    logic      config_rise;
    hscale_t   hscale_q;
    spin_vec_t spin_q;
    logic      busy_q;
    logic      issue_done_q;
    blk_addr_t blk_cnt_q;
    logic      blk_take;
    logic      blk_last;
    logic      start;
    energy_t   acc_q;
    energy_t   acc_sum;
    partial_t  part;
    logic      res_push;
    logic      res_ready;

    // config level to single pulse
    assign config_rise = config_valid_i & ~config_valid_q;

    // idle only when no computation runs and the result slot is empty
    assign spin_ready_o = ~busy_q & res_ready;
    assign start        = spin_valid_i & spin_ready_o;
    assign blk_ready_o  = busy_q & ~issue_done_q;
    assign blk_take     = blk_valid_i & blk_ready_o;
    assign blk_last     = (blk_cnt_q == blk_addr_t'(NUM_BLK - 1));
    assign acc_sum      = acc_q + part.energy;
    assign res_push     = part.valid & part.last;
    assign busy_o       = busy_q;
    assign start_o      = start;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            config_valid_q <= 1'b0;
            hscale_q       <= '0;
        end else begin
            config_valid_q <= config_valid_i;
            if (config_rise) begin
                hscale_q <= hscaling_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q       <= 1'b0;
            issue_done_q <= 1'b0;
            blk_cnt_q    <= '0;
        end else if (flush_i) begin
            busy_q       <= 1'b0;
            issue_done_q <= 1'b0;
            blk_cnt_q    <= '0;
        end else if (start) begin
            busy_q       <= 1'b1;
            issue_done_q <= 1'b0;
            blk_cnt_q    <= '0;
        end else begin
            if (blk_take) begin
                blk_cnt_q <= blk_cnt_q + 1'b1;
                if (blk_last) begin
                    issue_done_q <= 1'b1;
                end
            end
            if (res_push) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            spin_q <= spin_i;
            acc_q  <= '0;
        end else if (part.valid) begin
            acc_q <= acc_sum;
        end
    end

    block_energy u_block_energy (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .blk_valid_i (blk_take),
        .blk_i       (blk_i),
        .blk_idx_i   (blk_cnt_q),
        .last_i      (blk_last),
        .spin_i      (spin_q),
        .hbias_i     (hbias_i),
        .hscale_i    (hscale_q),
        .part_o      (part)
    );

    // single entry holds the total until the consumer takes it
    stream_fifo #(
        .payload_t (energy_t),
        .DEPTH     (1)
    ) u_result_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .in_valid_i  (res_push),
        .in_ready_o  (res_ready),
        .in_data_i   (acc_sum),
        .out_valid_o (energy_valid_o),
        .out_ready_i (energy_ready_i),
        .out_data_o  (energy_o),
        .free_o      ()
    );

endmodule

// ==== rtl/ising_energy_top.sv ====
// ising_energy_top: weight fetch, energy monitor and cycle counter wired together
`timescale 1ns/1ps

module ising_energy_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    // configuration levels
    input  logic                    config_valid_i,
    input  ising_pkg::hscale_t      hscaling_i,
    input  ising_pkg::hbias_vec_t   hbias_i,
    // spin stream
    input  logic                    spin_valid_i,
    output logic                    spin_ready_o,
    input  ising_pkg::spin_vec_t    spin_i,
    // energy stream
    output logic                    energy_valid_o,
    input  logic                    energy_ready_i,
    output ising_pkg::energy_t      energy_o,
    // J memory
    output ising_pkg::jmem_req_t    jmem_req_o,
    input  ising_pkg::weight_blk_t  jmem_rdata_i,
    // measurement
    output ising_pkg::cycle_cnt_t   cycle_per_cmpt_o
);

    import ising_pkg::*;

    logic        blk_valid;
    logic        blk_ready;
    weight_blk_t blk;
    logic        busy;
    logic        start;

    weight_fetch u_weight_fetch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .jmem_req_o   (jmem_req_o),
        .jmem_rdata_i (jmem_rdata_i),
        .blk_valid_o  (blk_valid),
        .blk_ready_i  (blk_ready),
        .blk_o        (blk)
    );

    energy_monitor u_energy_monitor (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .config_valid_i (config_valid_i),
        .hscaling_i     (hscaling_i),
        .hbias_i        (hbias_i),
        .spin_valid_i   (spin_valid_i),
        .spin_ready_o   (spin_ready_o),
        .spin_i         (spin_i),
        .blk_valid_i    (blk_valid),
        .blk_ready_o    (blk_ready),
        .blk_i          (blk),
        .energy_valid_o (energy_valid_o),
        .energy_ready_i (energy_ready_i),
        .energy_o       (energy_o),
        .busy_o         (busy),
        .start_o        (start)
    );

    cycle_counter u_cycle_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (start),
        .busy_i  (busy),
        .count_o (cycle_per_cmpt_o)
    );

endmodule

// ==== rtl/ising_pkg.sv ====
// shared types: spin vector, weight block, h biases, scale, energy, memory request, partial sum
`include "ising_config.svh"

package ising_pkg;

    typedef logic [`ISING_NUM_SPIN-1:0] spin_vec_t;

    // PARALLELISM rows, each NUM_SPIN weights, row 0 in the low bits
    typedef logic [`ISING_PARALLELISM*`ISING_NUM_SPIN*`ISING_BITJ-1:0] weight_blk_t;

    typedef logic [`ISING_NUM_SPIN*`ISING_BITJ-1:0] hbias_vec_t;

    typedef logic [`ISING_SCALING_BIT-1:0] hscale_t;

    typedef logic [`ISING_ADDR_BIT-1:0] blk_addr_t;

    typedef logic signed [`ISING_ENERGY_BIT-1:0] energy_t;

    typedef logic [`ISING_CNT_BIT-1:0] cycle_cnt_t;

    // read strobe plus block address, data back one cycle later
    typedef struct packed {
        logic      ren;
        blk_addr_t addr;
    } jmem_req_t;

    typedef struct packed {
        energy_t energy;
        logic    last;
        logic    valid;
    } partial_t;

endpackage

// ==== rtl/stream_fifo.sv ====
// stream_fifo: valid/ready circular buffer FIFO with typed payload and free-slot count
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2,
    parameter int  CNT_W     = $clog2(DEPTH + 1)
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    input  payload_t         in_data_i,
    output logic             out_valid_o,
    input  logic             out_ready_i,
    output payload_t         out_data_o,
    output logic [CNT_W-1:0] free_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             full_q;
    logic             empty_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push        = in_valid_i & ~full_q;
    assign pop         = out_ready_i & ~empty_q;
    assign in_ready_o  = ~full_q;
    assign out_valid_o = ~empty_q;
    assign out_data_o  = mem_q[rd_ptr_q];
    assign free_o      = CNT_W'(DEPTH) - count_q;

    always_comb begin
        case ({push, pop})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            full_q   <= 1'b0;
            empty_q  <= 1'b1;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            full_q   <= 1'b0;
            empty_q  <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q <= count_d;
            full_q  <= (count_d == CNT_W'(DEPTH));
            empty_q <= (count_d == '0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

endmodule

// ==== rtl/weight_fetch.sv ====
// weight_fetch: J memory read sequencer with credit check and weight block prefetch FIFO
`timescale 1ns/1ps
`include "ising_config.svh"

module weight_fetch (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    output ising_pkg::jmem_req_t    jmem_req_o,
    input  ising_pkg::weight_blk_t  jmem_rdata_i,
    output logic                    blk_valid_o,
    input  logic                    blk_ready_i,
    output ising_pkg::weight_blk_t  blk_o
);

    import ising_pkg::*;

    localparam int DEPTH = `ISING_WFIFO_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    jmem_req_t        req_q;
    blk_addr_t        addr_q;
    logic             rdata_valid_q;
    logic [CNT_W-1:0] fifo_free;
    logic [CNT_W-1:0] in_flight;
    logic             issue;

    // strobe on the bus and data landing now are not yet in the FIFO count
    assign in_flight = CNT_W'(req_q.ren) + CNT_W'(rdata_valid_q);
    assign issue     = (fifo_free > in_flight);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q         <= '0;
            addr_q        <= '0;
            rdata_valid_q <= 1'b0;
        end else if (flush_i) begin
            req_q         <= '0;
            addr_q        <= '0;
            rdata_valid_q <= 1'b0;
        end else begin
            req_q.ren <= issue;
            if (issue) begin
                req_q.addr <= addr_q;
                // wraps after the last block
                addr_q     <= addr_q + 1'b1;
            end
            rdata_valid_q <= req_q.ren;
        end
    end

    assign jmem_req_o = req_q;

    stream_fifo #(
        .payload_t (weight_blk_t),
        .DEPTH     (DEPTH)
    ) u_weight_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .in_valid_i  (rdata_valid_q),
        .in_ready_o  (),
        .in_data_i   (jmem_rdata_i),
        .out_valid_o (blk_valid_o),
        .out_ready_i (blk_ready_i),
        .out_data_o  (blk_o),
        .free_o      (fifo_free)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for the fail message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ising_energy -f list.f -o sim_ising_energy

status=0
./obj_dir/sim_ising_energy > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== verif/ising_energy_properties.sv ====
// ising_energy_properties: stream hold, reset strobe and idle assertions bound to the top level
`timescale 1ns/1ps

module ising_energy_properties (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  flush_i,
    input logic                  spin_valid_i,
    input logic                  spin_ready_o,
    input ising_pkg::spin_vec_t  spin_i,
    input logic                  energy_valid_o,
    input logic                  energy_ready_i,
    input ising_pkg::energy_t    energy_o,
    input ising_pkg::jmem_req_t  jmem_req_o
);

    // a stalled source keeps valid and data
    a_spin_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        spin_valid_i && !spin_ready_o |=> spin_valid_i && $stable(spin_i)
    ) else $error("spin stream dropped valid or changed data while stalled");

    a_energy_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        energy_valid_o && !energy_ready_i |=> energy_valid_o && $stable(energy_o)
    ) else $error("energy stream dropped valid or changed data while stalled");

    a_no_read_in_reset: assert property (
        @(posedge clk_i) !rst_n_i |-> !jmem_req_o.ren
    ) else $error("J memory strobe during reset");

    // a waiting result blocks new spin vectors
    a_busy_while_result: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        energy_valid_o |-> !spin_ready_o
    ) else $error("spin_ready_o high while energy_valid_o is high");

endmodule

bind ising_energy_top ising_energy_properties u_properties (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .spin_valid_i   (spin_valid_i),
    .spin_ready_o   (spin_ready_o),
    .spin_i         (spin_i),
    .energy_valid_o (energy_valid_o),
    .energy_ready_i (energy_ready_i),
    .energy_o       (energy_o),
    .jmem_req_o     (jmem_req_o)
);

// ==== verif/tb_ising_energy.sv ====
// tb_ising_energy: clock, reset, LFSR stimulus, J memory model, energy reference model, checks, watchdog
`timescale 1ns/1ps
`include "ising_config.svh"

module tb_ising_energy;

    import ising_pkg::*;

    localparam int NUM_SPIN   = `ISING_NUM_SPIN;
    localparam int PAR        = `ISING_PARALLELISM;
    localparam int BITJ       = `ISING_BITJ;
    localparam int SCALE_BIT  = `ISING_SCALING_BIT;
    localparam int NUM_BLK    = NUM_SPIN / PAR;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_RANDOM = 20;
    localparam int NUM_STALL  = 10;
    // every vector sent, the flushed one included
    localparam int NUM_VECTORS     = NUM_RANDOM + 2 + NUM_STALL + 2;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * 64;
    localparam int WAIT_LIMIT      = 64;

    logic        clk_i;
    logic        rst_n_i;
    logic        flush_i;
    logic        config_valid_i;
    hscale_t     hscaling_i;
    hbias_vec_t  hbias_i;
    logic        spin_valid_i;
    logic        spin_ready_o;
    spin_vec_t   spin_i;
    logic        energy_valid_o;
    logic        energy_ready_i;
    energy_t     energy_o;
    jmem_req_t   jmem_req_o;
    weight_blk_t jmem_rdata_i;
    cycle_cnt_t  cycle_per_cmpt_o;

    logic [31:0] lfsr_state;
    int          jmat [NUM_SPIN][NUM_SPIN];
    int          hval [NUM_SPIN];
    weight_blk_t jmem [NUM_BLK];
    int          scale_model;
    logic        rd_pending;
    blk_addr_t   rd_addr;
    int          n_checks;
    int          n_errors;
    int          test_errors;

    ising_energy_top u_ising_energy_top (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .config_valid_i   (config_valid_i),
        .hscaling_i       (hscaling_i),
        .hbias_i          (hbias_i),
        .spin_valid_i     (spin_valid_i),
        .spin_ready_o     (spin_ready_o),
        .spin_i           (spin_i),
        .energy_valid_o   (energy_valid_o),
        .energy_ready_i   (energy_ready_i),
        .energy_o         (energy_o),
        .jmem_req_o       (jmem_req_o),
        .jmem_rdata_i     (jmem_rdata_i),
        .cycle_per_cmpt_o (cycle_per_cmpt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < nbits; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // two's complement value of a BITJ-wide field
    function automatic int weight_value(input logic [31:0] raw);
        int v;
        v = int'(raw[BITJ-1:0]);
        if (raw[BITJ-1]) begin
            v = v - (1 << BITJ);
        end
        return v;
    endfunction

    function automatic int spin_sign(input logic s);
        return s ? 1 : -1;
    endfunction

    // E = sum_i s_i * (sum_j J_ij * s_j + h_i * scale)
    function automatic longint model_energy(input spin_vec_t spin);
        longint total;
        longint field;
        total = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            field = longint'(hval[i] * scale_model);
            for (int j = 0; j < NUM_SPIN; j++) begin
                field = field + longint'(jmat[i][j] * spin_sign(spin[j]));
            end
            total = total + longint'(spin_sign(spin[i])) * field;
        end
        return total;
    endfunction

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        n_errors++;
        test_errors++;
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        n_checks++;
        if (expected != actual) begin
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-14s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
                 test_errors);
        test_errors = 0;
    endtask

    // word a holds rows a*PAR .. a*PAR+PAR-1, row r in the low bits
    task automatic fill_jmem();
        int row;
        for (int i = 0; i < NUM_SPIN; i++) begin
            for (int j = 0; j < NUM_SPIN; j++) begin
                jmat[i][j] = weight_value(rand_bits(BITJ));
            end
        end
        for (int a = 0; a < NUM_BLK; a++) begin
            jmem[a] = '0;
            for (int r = 0; r < PAR; r++) begin
                row = a * PAR + r;
                for (int j = 0; j < NUM_SPIN; j++) begin
                    jmem[a][(r*NUM_SPIN + j)*BITJ +: BITJ] = BITJ'(jmat[row][j]);
                end
            end
        end
    endtask

    task automatic new_hbias();
        for (int i = 0; i < NUM_SPIN; i++) begin
            hval[i]                   = weight_value(rand_bits(BITJ));
            hbias_i[i*BITJ +: BITJ] = BITJ'(hval[i]);
        end
    endtask

    task automatic send_spin(input spin_vec_t spin, output bit accepted);
        int n;
        n            = 0;
        spin_valid_i = 1'b1;
        spin_i       = spin;
        while (!spin_ready_o && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        accepted = spin_ready_o;
        if (!accepted) begin
            report_error("spin_ready_o stayed low, the spin vector was never accepted");
        end else begin
            step();
        end
        spin_valid_i = 1'b0;
    endtask

    // counts cycles from the spin handshake, optionally stalls the result stream
    task automatic wait_result(input string name, input longint expected, input bit stall);
        int      n;
        int      stretch;
        energy_t held;
        n = 0;
        while (!energy_valid_o && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!energy_valid_o) begin
            report_error({name, ": no energy result after the spin handshake"});
            return;
        end
        check_value({name, " cycles"}, longint'(n), longint'(cycle_per_cmpt_o));
        held    = energy_o;
        stretch = stall ? int'(rand_bits(4)) : 0;
        repeat (stretch) begin
            step();
            if (!energy_valid_o || energy_o != held) begin
                report_error({name, ": result dropped or changed while energy_ready_i was low"});
            end
            if (spin_ready_o) begin
                report_error({name, ": spin_ready_o high while a result was waiting"});
            end
        end
        check_value(name, expected, longint'(energy_o));
        energy_ready_i = 1'b1;
        step();
        energy_ready_i = 1'b0;
    endtask

    task automatic run_vector(input string name, input bit stall);
        spin_vec_t spin;
        longint    expected;
        bit        accepted;
        spin     = spin_vec_t'(rand_bits(NUM_SPIN));
        expected = model_energy(spin);
        send_spin(spin, accepted);
        if (accepted) begin
            wait_result(name, expected, stall);
        end
    endtask

    // J memory answers each strobe during the following cycle
    initial begin
        jmem_rdata_i = '0;
        rd_pending   = 1'b0;
        rd_addr      = '0;
        forever begin
            @(posedge clk_i);
            #1;
            jmem_rdata_i = rd_pending ? jmem[rd_addr] : '0;
            rd_pending   = jmem_req_o.ren;
            rd_addr      = jmem_req_o.addr;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        spin_vec_t spin;
        bit        accepted;
        int        delay;
        hscale_t   next_scale;
        lfsr_state     = 32'h4cc44314;
        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        config_valid_i = 1'b0;
        hscaling_i     = '0;
        hbias_i        = '0;
        spin_valid_i   = 1'b0;
        spin_i         = '0;
        energy_ready_i = 1'b0;
        n_checks       = 0;
        n_errors       = 0;
        test_errors    = 0;
        scale_model    = 0;
        fill_jmem();
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        step();

        check_value("reset energy_valid_o", 0, longint'(energy_valid_o));
        check_value("reset spin_ready_o", 1, longint'(spin_ready_o));
        check_value("reset cycle_per_cmpt_o", 0, longint'(cycle_per_cmpt_o));
        finish_test("reset_state");

        // scale taken on the rising edge, level then stays high
        hscaling_i     = hscale_t'(rand_bits(SCALE_BIT)) | hscale_t'(1);
        config_valid_i = 1'b1;
        scale_model    = int'(hscaling_i);
        step();
        repeat (NUM_RANDOM) begin
            new_hbias();
            run_vector("random_energy", 1'b0);
        end
        finish_test("random_energy");

        next_scale = hscaling_i ^ hscale_t'(6);
        hscaling_i = next_scale;
        repeat (3) step();
        run_vector("scale_held", 1'b0);
        config_valid_i = 1'b0;
        step();
        config_valid_i = 1'b1;
        step();
        scale_model = int'(next_scale);
        run_vector("scale_rise", 1'b0);
        finish_test("config_scale");

        repeat (NUM_STALL) begin
            new_hbias();
            run_vector("backpressure", 1'b1);
        end
        finish_test("backpressure");

        // flush well before the earliest possible result
        spin = spin_vec_t'(rand_bits(NUM_SPIN));
        send_spin(spin, accepted);
        delay = 1 + int'(rand_bits(2)) % 3;
        repeat (delay) step();
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        n_checks++;
        repeat (12) begin
            step();
            if (energy_valid_o) begin
                report_error("energy_valid_o rose for a flushed spin vector");
            end
        end
        if (!spin_ready_o) begin
            report_error("spin_ready_o still low after the flush");
        end
        new_hbias();
        run_vector("flush_recover", 1'b0);
        finish_test("flush");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
